// File: hdl/host_ctrl_pkg.sv
package host_ctrl_pkg;

  // Bus and address widths
  localparam int unsigned LITE_AW = 32;
  localparam int unsigned LITE_DW = 32;
  localparam int unsigned ADDR_W = 64;

  // LLC events, also the counter order
  localparam int unsigned NUM_LLC_EVENTS = 4;
  localparam int unsigned EVT_READ_HIT = 0;
  localparam int unsigned EVT_READ_MISS = 1;
  localparam int unsigned EVT_WRITE_HIT = 2;
  localparam int unsigned EVT_WRITE_MISS = 3;

  // Register map, only the low byte of the address is decoded
  localparam int unsigned REG_OFFSET_W = 8;
  localparam logic [REG_OFFSET_W-1:0] REG_CACHE_START = 8'h00;
  localparam logic [REG_OFFSET_W-1:0] REG_CACHE_END = 8'h04;
  localparam logic [REG_OFFSET_W-1:0] REG_SPM_START = 8'h08;
  localparam logic [REG_OFFSET_W-1:0] REG_CNT_READ_HIT = 8'h10;
  localparam logic [REG_OFFSET_W-1:0] REG_CNT_READ_MISS = 8'h14;
  localparam logic [REG_OFFSET_W-1:0] REG_CNT_WRITE_HIT = 8'h18;
  localparam logic [REG_OFFSET_W-1:0] REG_CNT_WRITE_MISS = 8'h1C;

  localparam logic [LITE_DW-1:0] UNMAPPED_RDATA = 32'hDEAD_F000;

  // Scratchpad window is 64 KiB
  localparam logic [ADDR_W-1:0] SPM_SIZE = 64'h0000_0000_0001_0000;

  // Region codes
  localparam int unsigned REGION_W = 2;
  localparam logic [REGION_W-1:0] REGION_BYPASS = 2'd0;
  localparam logic [REGION_W-1:0] REGION_CACHED = 2'd1;
  localparam logic [REGION_W-1:0] REGION_SPM = 2'd2;

endpackage

// File: hdl/llc_cfg_regs.sv
`timescale 1ns/1ns

module llc_cfg_regs
  import host_ctrl_pkg::*;
(
  input  logic                                    clk_i,
  input  logic                                    rst_n_i,
  input  logic                                    cfg_aw_valid_i,
  output logic                                    cfg_aw_ready_o,
  input  logic [LITE_AW-1:0]                      cfg_aw_addr_i,
  input  logic                                    cfg_w_valid_i,
  output logic                                    cfg_w_ready_o,
  input  logic [LITE_DW-1:0]                      cfg_w_data_i,
  output logic                                    cfg_b_valid_o,
  input  logic                                    cfg_b_ready_i,
  input  logic                                    cfg_ar_valid_i,
  output logic                                    cfg_ar_ready_o,
  input  logic [LITE_AW-1:0]                      cfg_ar_addr_i,
  output logic                                    cfg_r_valid_o,
  input  logic                                    cfg_r_ready_i,
  output logic [LITE_DW-1:0]                      cfg_r_data_o,
  input  logic [NUM_LLC_EVENTS-1:0][LITE_DW-1:0]  cnt_i,
  output logic [NUM_LLC_EVENTS-1:0]               cnt_clr_o,
  output logic [LITE_DW-1:0]                      cache_start_o,
  output logic [LITE_DW-1:0]                      cache_end_o,
  output logic [LITE_DW-1:0]                      spm_start_o
);

  logic                     b_pending_q;
  logic                     r_pending_q;
  logic [LITE_DW-1:0]       r_data_q;
  logic                     wr_en;
  logic                     rd_en;
  logic [REG_OFFSET_W-1:0]  wr_offset;
  logic [REG_OFFSET_W-1:0]  rd_offset;
  logic [LITE_DW-1:0]       rd_data;

  // One write and one read in flight at most
  assign cfg_aw_ready_o = !b_pending_q;
  assign cfg_w_ready_o  = !b_pending_q;
  assign cfg_ar_ready_o = !r_pending_q;

  assign wr_en     = cfg_aw_valid_i && cfg_w_valid_i && !b_pending_q;
  assign rd_en     = cfg_ar_valid_i && !r_pending_q;
  assign wr_offset = cfg_aw_addr_i[REG_OFFSET_W-1:0];
  assign rd_offset = cfg_ar_addr_i[REG_OFFSET_W-1:0];

  assign cfg_b_valid_o = b_pending_q;
  assign cfg_r_valid_o = r_pending_q;
  assign cfg_r_data_o  = r_data_q;

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      b_pending_q <= 1'b0;
    end else if (wr_en) begin
      b_pending_q <= 1'b1;
    end else if (cfg_b_ready_i) begin
      b_pending_q <= 1'b0;
    end
  end

  // Window registers, unmapped writes fall through
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      cache_start_o <= '0;
      cache_end_o   <= '0;
      spm_start_o   <= '0;
    end else if (wr_en) begin
      case (wr_offset)
        REG_CACHE_START: cache_start_o <= cfg_w_data_i;
        REG_CACHE_END:   cache_end_o   <= cfg_w_data_i;
        REG_SPM_START:   spm_start_o   <= cfg_w_data_i;
        default: ;
      endcase
    end
  end

  // Any write to a counter offset clears it
  always_comb begin
    cnt_clr_o = '0;
    if (wr_en) begin
      case (wr_offset)
        REG_CNT_READ_HIT:   cnt_clr_o[EVT_READ_HIT]   = 1'b1;
        REG_CNT_READ_MISS:  cnt_clr_o[EVT_READ_MISS]  = 1'b1;
        REG_CNT_WRITE_HIT:  cnt_clr_o[EVT_WRITE_HIT]  = 1'b1;
        REG_CNT_WRITE_MISS: cnt_clr_o[EVT_WRITE_MISS] = 1'b1;
        default: ;
      endcase
    end
  end

  always_comb begin
    case (rd_offset)
      REG_CACHE_START:    rd_data = cache_start_o;
      REG_CACHE_END:      rd_data = cache_end_o;
      REG_SPM_START:      rd_data = spm_start_o;
      REG_CNT_READ_HIT:   rd_data = cnt_i[EVT_READ_HIT];
      REG_CNT_READ_MISS:  rd_data = cnt_i[EVT_READ_MISS];
      REG_CNT_WRITE_HIT:  rd_data = cnt_i[EVT_WRITE_HIT];
      REG_CNT_WRITE_MISS: rd_data = cnt_i[EVT_WRITE_MISS];
      default:            rd_data = UNMAPPED_RDATA;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      r_pending_q <= 1'b0;
    end else if (rd_en) begin
      r_pending_q <= 1'b1;
    end else if (cfg_r_ready_i) begin
      r_pending_q <= 1'b0;
    end
  end

  // Read data is captured at acceptance and held
  always_ff @(posedge clk_i) begin
    if (rd_en) begin
      r_data_q <= rd_data;
    end
  end

  // Stalled read response must not change
  assert property (@(posedge clk_i) disable iff (!rst_n_i)
    cfg_r_valid_o && !cfg_r_ready_i |=> cfg_r_valid_o && $stable(cfg_r_data_o));

  assert property (@(posedge clk_i) disable iff (!rst_n_i)
    cfg_b_valid_o && !cfg_b_ready_i |=> cfg_b_valid_o);

endmodule

// File: hdl/llc_event_counters.sv
`timescale 1ns/1ns

module llc_event_counters
  import host_ctrl_pkg::*;
(
  input  logic                                    clk_i,
  input  logic                                    rst_n_i,
  input  logic [NUM_LLC_EVENTS-1:0]               evt_i,
  input  logic [NUM_LLC_EVENTS-1:0]               clr_i,
  output logic [NUM_LLC_EVENTS-1:0][LITE_DW-1:0]  cnt_o
);

  logic [NUM_LLC_EVENTS-1:0][LITE_DW-1:0] cnt_q;

  assign cnt_o = cnt_q;

  // Clear beats a coincident event, counters wrap
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      cnt_q <= '0;
    end else begin
      for (int i = 0; i < NUM_LLC_EVENTS; i++) begin
        if (clr_i[i]) begin
          cnt_q[i] <= '0;
        end else if (evt_i[i]) begin
          cnt_q[i] <= cnt_q[i] + 1'b1;
        end
      end
    end
  end

  for (genvar g = 0; g < NUM_LLC_EVENTS; g++) begin : gen_clr_check
    assert property (@(posedge clk_i) disable iff (!rst_n_i)
      clr_i[g] |=> cnt_o[g] == '0);
  end

endmodule

// File: hdl/llc_region_decode.sv
`timescale 1ns/1ns

module llc_region_decode
  import host_ctrl_pkg::*;
(
  input  logic                 clk_i,
  input  logic                 rst_n_i,
  input  logic                 access_valid_i,
  input  logic [ADDR_W-1:0]    access_addr_i,
  input  logic [LITE_DW-1:0]   cache_start_i,
  input  logic [LITE_DW-1:0]   cache_end_i,
  input  logic [LITE_DW-1:0]   spm_start_i,
  output logic                 region_valid_o,
  output logic [REGION_W-1:0]  region_o
);

  logic [ADDR_W-1:0]    cache_start_ext;
  logic [ADDR_W-1:0]    cache_end_ext;
  logic [ADDR_W-1:0]    spm_start_ext;
  logic [ADDR_W-1:0]    spm_end_ext;
  logic                 in_cached;
  logic                 in_spm;
  logic [REGION_W-1:0]  region_d;

  // Windows live in the low 4 GiB
  assign cache_start_ext = {{(ADDR_W-LITE_DW){1'b0}}, cache_start_i};
  assign cache_end_ext   = {{(ADDR_W-LITE_DW){1'b0}}, cache_end_i};
  assign spm_start_ext   = {{(ADDR_W-LITE_DW){1'b0}}, spm_start_i};
  assign spm_end_ext     = spm_start_ext + SPM_SIZE;

  assign in_cached = (access_addr_i >= cache_start_ext) && (access_addr_i < cache_end_ext);
  assign in_spm    = (access_addr_i >= spm_start_ext) && (access_addr_i < spm_end_ext);

  // Cached window has priority over the scratchpad
  always_comb begin
    if (in_cached) begin
      region_d = REGION_CACHED;
    end else if (in_spm) begin
      region_d = REGION_SPM;
    end else begin
      region_d = REGION_BYPASS;
    end
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      region_valid_o <= 1'b0;
    end else begin
      region_valid_o <= access_valid_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (access_valid_i) begin
      region_o <= region_d;
    end
  end

  assert property (@(posedge clk_i) disable iff (!rst_n_i)
    access_valid_i |=> region_valid_o);

  assert property (@(posedge clk_i) disable iff (!rst_n_i)
    !access_valid_i |=> !region_valid_o);

endmodule

// File: hdl/dma_evt_rx.sv
`timescale 1ns/1ns

module dma_evt_rx
  import host_ctrl_pkg::*;
(
  input  logic clk_i,
  input  logic rst_n_i,
  input  logic valid_i,
  output logic valid_o,
  output logic ack_o
);

  logic sync1_q;
  logic sync2_q;
  logic dly_q;

  // Two flops for the asynchronous toggle, then one for edge detect
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      sync1_q <= 1'b0;
      sync2_q <= 1'b0;
      dly_q   <= 1'b0;
    end else begin
      sync1_q <= valid_i;
      sync2_q <= sync1_q;
      dly_q   <= sync2_q;
    end
  end

  // Any level change is one event
  assign valid_o = sync2_q ^ dly_q;
  assign ack_o   = sync2_q;

  assert property (@(posedge clk_i) disable iff (!rst_n_i)
    valid_o |=> !valid_o);

endmodule

// File: hdl/host_ctrl_top.sv
`timescale 1ns/1ns

module host_ctrl_top
  import host_ctrl_pkg::*;
(
  input  logic                        clk_i,
  input  logic                        rst_n_i,
  input  logic                        cfg_aw_valid_i,
  output logic                        cfg_aw_ready_o,
  input  logic [LITE_AW-1:0]          cfg_aw_addr_i,
  input  logic                        cfg_w_valid_i,
  output logic                        cfg_w_ready_o,
  input  logic [LITE_DW-1:0]          cfg_w_data_i,
  output logic                        cfg_b_valid_o,
  input  logic                        cfg_b_ready_i,
  input  logic                        cfg_ar_valid_i,
  output logic                        cfg_ar_ready_o,
  input  logic [LITE_AW-1:0]          cfg_ar_addr_i,
  output logic                        cfg_r_valid_o,
  input  logic                        cfg_r_ready_i,
  output logic [LITE_DW-1:0]          cfg_r_data_o,
  input  logic [NUM_LLC_EVENTS-1:0]   llc_evt_i,
  input  logic                        access_valid_i,
  input  logic [ADDR_W-1:0]           access_addr_i,
  output logic                        region_valid_o,
  output logic [REGION_W-1:0]         region_o,
  input  logic                        dma_evt_valid_i,
  output logic                        dma_evt_ack_o,
  output logic                        dma_evt_o
);

  logic [NUM_LLC_EVENTS-1:0][LITE_DW-1:0] cnt;
  logic [NUM_LLC_EVENTS-1:0]              cnt_clr;
  logic [LITE_DW-1:0]                     cache_start;
  logic [LITE_DW-1:0]                     cache_end;
  logic [LITE_DW-1:0]                     spm_start;

  llc_cfg_regs i_llc_cfg_regs (
    .clk_i          ( clk_i          ),
    .rst_n_i        ( rst_n_i        ),
    .cfg_aw_valid_i ( cfg_aw_valid_i ),
    .cfg_aw_ready_o ( cfg_aw_ready_o ),
    .cfg_aw_addr_i  ( cfg_aw_addr_i  ),
    .cfg_w_valid_i  ( cfg_w_valid_i  ),
    .cfg_w_ready_o  ( cfg_w_ready_o  ),
    .cfg_w_data_i   ( cfg_w_data_i   ),
    .cfg_b_valid_o  ( cfg_b_valid_o  ),
    .cfg_b_ready_i  ( cfg_b_ready_i  ),
    .cfg_ar_valid_i ( cfg_ar_valid_i ),
    .cfg_ar_ready_o ( cfg_ar_ready_o ),
    .cfg_ar_addr_i  ( cfg_ar_addr_i  ),
    .cfg_r_valid_o  ( cfg_r_valid_o  ),
    .cfg_r_ready_i  ( cfg_r_ready_i  ),
    .cfg_r_data_o   ( cfg_r_data_o   ),
    .cnt_i          ( cnt            ),
    .cnt_clr_o      ( cnt_clr        ),
    .cache_start_o  ( cache_start    ),
    .cache_end_o    ( cache_end      ),
    .spm_start_o    ( spm_start      )
  );

  llc_event_counters i_llc_event_counters (
    .clk_i   ( clk_i     ),
    .rst_n_i ( rst_n_i   ),
    .evt_i   ( llc_evt_i ),
    .clr_i   ( cnt_clr   ),
    .cnt_o   ( cnt       )
  );

  llc_region_decode i_llc_region_decode (
    .clk_i          ( clk_i          ),
    .rst_n_i        ( rst_n_i        ),
    .access_valid_i ( access_valid_i ),
    .access_addr_i  ( access_addr_i  ),
    .cache_start_i  ( cache_start    ),
    .cache_end_i    ( cache_end      ),
    .spm_start_i    ( spm_start      ),
    .region_valid_o ( region_valid_o ),
    .region_o       ( region_o       )
  );

  // Cluster DMA event crosses in here
  dma_evt_rx i_dma_evt_rx (
    .clk_i   ( clk_i           ),
    .rst_n_i ( rst_n_i         ),
    .valid_i ( dma_evt_valid_i ),
    .valid_o ( dma_evt_o       ),
    .ack_o   ( dma_evt_ack_o   )
  );

endmodule

// File: tests/host_ctrl_tb.sv
`timescale 1ns/1ns

module host_ctrl_tb
  import host_ctrl_pkg::*;
();

  logic                       clk_i;
  logic                       rst_n_i;
  logic                       cfg_aw_valid_i;
  logic                       cfg_aw_ready_o;
  logic [LITE_AW-1:0]         cfg_aw_addr_i;
  logic                       cfg_w_valid_i;
  logic                       cfg_w_ready_o;
  logic [LITE_DW-1:0]         cfg_w_data_i;
  logic                       cfg_b_valid_o;
  logic                       cfg_b_ready_i;
  logic                       cfg_ar_valid_i;
  logic                       cfg_ar_ready_o;
  logic [LITE_AW-1:0]         cfg_ar_addr_i;
  logic                       cfg_r_valid_o;
  logic                       cfg_r_ready_i;
  logic [LITE_DW-1:0]         cfg_r_data_o;
  logic [NUM_LLC_EVENTS-1:0]  llc_evt_i;
  logic                       access_valid_i;
  logic [ADDR_W-1:0]          access_addr_i;
  logic                       region_valid_o;
  logic [REGION_W-1:0]        region_o;
  logic                       dma_evt_valid_i;
  logic                       dma_evt_ack_o;
  logic                       dma_evt_o;

  // Reference model state
  integer               seed;
  logic [LITE_DW-1:0]   rnd;
  logic [LITE_DW-1:0]   exp_rdata;
  logic [LITE_DW-1:0]   model_cnt [NUM_LLC_EVENTS];
  logic [7:0]           cnt_offs [NUM_LLC_EVENTS];
  logic [LITE_DW-1:0]   win_cache_start;
  logic [LITE_DW-1:0]   win_cache_end;
  logic [LITE_DW-1:0]   win_spm_start;
  logic [REGION_W-1:0]  exp_region;
  logic [REGION_W-1:0]  exp_region_q;
  logic                 exp_region_valid_q;
  logic [2:0]           dma_hist;
  logic [7:0]           status_vec;
  int                   dma_toggles = 0;
  int                   dma_pulses = 0;

  host_ctrl_top host_ctrl_top_inst (.*);

  initial begin
    clk_i = 1'b0;
    forever #5 clk_i = ~clk_i;
  end

  // Expected responses one cycle behind the request
  always @(posedge clk_i) begin
    exp_region_valid_q <= access_valid_i;
    exp_region_q       <= exp_region;
    dma_hist           <= {dma_hist[1:0], dma_evt_valid_i};
  end

  always @(negedge clk_i) begin
    if (rst_n_i && dma_evt_o) begin
      dma_pulses <= dma_pulses + 1;
    end
  end

  task automatic report_mismatch(input string name, input logic [63:0] expv,
                                 input logic [63:0] actv);
    $display("FAILED %s expected %h actual %h", name, expv, actv);
    $display("RESULT: FAIL");
    $fatal(1);
  endtask

  task automatic report_failure(input string what);
    $display("Error: %s", what);
    $display("RESULT: FAIL");
    $fatal(1);
  endtask

  assign status_vec = {cfg_b_valid_o, cfg_r_valid_o, region_valid_o, dma_evt_o, dma_evt_ack_o,
                       cfg_aw_ready_o, cfg_w_ready_o, cfg_ar_ready_o};

  assert property (@(posedge clk_i) $rose(rst_n_i) |-> status_vec == 8'h07)
    else report_mismatch("status after reset", 64'h07, 64'($sampled(status_vec)));
  assert property (@(posedge clk_i) disable iff (!rst_n_i)
    cfg_aw_ready_o == !cfg_b_valid_o && cfg_w_ready_o == !cfg_b_valid_o)
    else report_failure("write channel ready does not match pending response");
  assert property (@(posedge clk_i) disable iff (!rst_n_i)
    cfg_aw_valid_i && cfg_w_valid_i && cfg_aw_ready_o && cfg_w_ready_o |=> cfg_b_valid_o)
    else report_failure("write response did not follow acceptance");
  assert property (@(posedge clk_i) disable iff (!rst_n_i)
    cfg_b_valid_o && !cfg_b_ready_i |=> cfg_b_valid_o)
    else report_failure("write response dropped while stalled");
  assert property (@(posedge clk_i) disable iff (!rst_n_i)
    cfg_b_valid_o && cfg_b_ready_i |=> !cfg_b_valid_o)
    else report_failure("write response held after handshake");
  assert property (@(posedge clk_i) disable iff (!rst_n_i)
    cfg_ar_ready_o == !cfg_r_valid_o)
    else report_failure("read channel ready does not match pending response");
  assert property (@(posedge clk_i) disable iff (!rst_n_i)
    cfg_ar_valid_i && cfg_ar_ready_o |=> cfg_r_valid_o)
    else report_failure("read response did not follow acceptance");
  assert property (@(posedge clk_i) disable iff (!rst_n_i)
    cfg_r_valid_o && !cfg_r_ready_i |=> cfg_r_valid_o && $stable(cfg_r_data_o))
    else report_failure("read response changed while stalled");
  assert property (@(posedge clk_i) disable iff (!rst_n_i)
    cfg_r_valid_o && cfg_r_ready_i |=> !cfg_r_valid_o)
    else report_failure("read response held after handshake");
  assert property (@(posedge clk_i) disable iff (!rst_n_i)
    cfg_r_valid_o |-> cfg_r_data_o == exp_rdata)
    else report_mismatch("cfg_r_data_o", 64'(exp_rdata), 64'($sampled(cfg_r_data_o)));
  assert property (@(posedge clk_i) disable iff (!rst_n_i)
    region_valid_o == exp_region_valid_q)
    else report_mismatch("region_valid_o", 64'($sampled(exp_region_valid_q)),
                         64'($sampled(region_valid_o)));
  assert property (@(posedge clk_i) disable iff (!rst_n_i)
    region_valid_o |-> region_o == exp_region_q)
    else report_mismatch("region_o", 64'($sampled(exp_region_q)), 64'($sampled(region_o)));
  assert property (@(posedge clk_i) disable iff (!rst_n_i)
    dma_evt_o == (dma_hist[1] ^ dma_hist[2]))
    else report_mismatch("dma_evt_o", 64'($sampled(dma_hist[1]) ^ $sampled(dma_hist[2])),
                         64'($sampled(dma_evt_o)));
  assert property (@(posedge clk_i) disable iff (!rst_n_i)
    dma_evt_ack_o == dma_hist[1])
    else report_mismatch("dma_evt_ack_o", 64'($sampled(dma_hist[1])),
                         64'($sampled(dma_evt_ack_o)));

  // Priority rule, cached window first
  function automatic logic [REGION_W-1:0] region_of(input logic [ADDR_W-1:0] addr);
    if (addr >= ADDR_W'(win_cache_start) && addr < ADDR_W'(win_cache_end)) return REGION_CACHED;
    if (addr >= ADDR_W'(win_spm_start) && addr < ADDR_W'(win_spm_start) + SPM_SIZE) begin
      return REGION_SPM;
    end
    return REGION_BYPASS;
  endfunction

  task automatic hold_ready_low();
    rnd = $random(seed);
    repeat (rnd[2:0]) begin
      @(posedge clk_i);
      #1;
    end
  endtask

  task automatic cfg_write(input logic [7:0] offset, input logic [LITE_DW-1:0] data);
    int n;
    cfg_aw_valid_i = 1'b1;
    cfg_w_valid_i  = 1'b1;
    cfg_aw_addr_i  = LITE_AW'(offset);
    cfg_w_data_i   = data;
    n = 0;
    while (!(cfg_aw_ready_o && cfg_w_ready_o)) begin
      @(posedge clk_i);
      #1;
      n++;
      if (n > 50) report_failure("write request was never accepted");
    end
    @(posedge clk_i);
    #1;
    cfg_aw_valid_i = 1'b0;
    cfg_w_valid_i  = 1'b0;
    n = 0;
    while (!cfg_b_valid_o) begin
      @(posedge clk_i);
      #1;
      n++;
      if (n > 50) report_failure("write response never arrived");
    end
    hold_ready_low();
    cfg_b_ready_i = 1'b1;
    @(posedge clk_i);
    #1;
    cfg_b_ready_i = 1'b0;
  endtask

  task automatic cfg_read(input logic [7:0] offset, input logic [LITE_DW-1:0] expected);
    int n;
    exp_rdata      = expected;
    cfg_ar_valid_i = 1'b1;
    cfg_ar_addr_i  = LITE_AW'(offset);
    n = 0;
    while (!cfg_ar_ready_o) begin
      @(posedge clk_i);
      #1;
      n++;
      if (n > 50) report_failure("read request was never accepted");
    end
    @(posedge clk_i);
    #1;
    cfg_ar_valid_i = 1'b0;
    n = 0;
    while (!cfg_r_valid_o) begin
      @(posedge clk_i);
      #1;
      n++;
      if (n > 50) report_failure("read response never arrived");
    end
    // Competing read to an unmapped offset waits behind the stalled response
    cfg_ar_valid_i = 1'b1;
    cfg_ar_addr_i  = LITE_AW'(~offset);
    hold_ready_low();
    cfg_r_ready_i = 1'b1;
    @(posedge clk_i);
    #1;
    cfg_r_ready_i  = 1'b0;
    cfg_ar_valid_i = 1'b0;
  endtask

  task automatic set_windows(input logic [LITE_DW-1:0] cs, input logic [LITE_DW-1:0] ce,
                             input logic [LITE_DW-1:0] ss);
    win_cache_start = cs;
    win_cache_end   = ce;
    win_spm_start   = ss;
    cfg_write(REG_CACHE_START, cs);
    cfg_write(REG_CACHE_END, ce);
    cfg_write(REG_SPM_START, ss);
  endtask

  task automatic pulse_events(input int cycles);
    for (int c = 0; c < cycles; c++) begin
      rnd = $random(seed);
      llc_evt_i = rnd[NUM_LLC_EVENTS-1:0];
      for (int i = 0; i < NUM_LLC_EVENTS; i++) begin
        if (rnd[i]) model_cnt[i] = model_cnt[i] + 32'd1;
      end
      @(posedge clk_i);
      #1;
    end
    llc_evt_i = '0;
  endtask

  task automatic send_access(input logic [ADDR_W-1:0] addr, input logic valid);
    access_valid_i = valid;
    access_addr_i  = addr;
    exp_region     = region_of(addr);
    @(posedge clk_i);
    #1;
  endtask

  task automatic check_counters();
    for (int i = 0; i < NUM_LLC_EVENTS; i++) begin
      cfg_read(cnt_offs[i], model_cnt[i]);
    end
  endtask

  initial begin
    int n;
    logic [ADDR_W-1:0] base;
    seed            = 39525;
    rst_n_i         = 1'b0;
    cfg_aw_valid_i  = 1'b0;
    cfg_aw_addr_i   = '0;
    cfg_w_valid_i   = 1'b0;
    cfg_w_data_i    = '0;
    cfg_b_ready_i   = 1'b0;
    cfg_ar_valid_i  = 1'b0;
    cfg_ar_addr_i   = '0;
    cfg_r_ready_i   = 1'b0;
    llc_evt_i       = '0;
    access_valid_i  = 1'b0;
    access_addr_i   = '0;
    dma_evt_valid_i = 1'b0;
    exp_rdata       = '0;
    exp_region      = REGION_BYPASS;
    cnt_offs[EVT_READ_HIT]   = REG_CNT_READ_HIT;
    cnt_offs[EVT_READ_MISS]  = REG_CNT_READ_MISS;
    cnt_offs[EVT_WRITE_HIT]  = REG_CNT_WRITE_HIT;
    cnt_offs[EVT_WRITE_MISS] = REG_CNT_WRITE_MISS;
    for (int i = 0; i < NUM_LLC_EVENTS; i++) begin
      model_cnt[i] = '0;
    end
    repeat (10) @(posedge clk_i);
    #1;
    rst_n_i = 1'b1;

    cfg_read(REG_CACHE_START, '0);
    cfg_read(REG_CACHE_END, '0);
    cfg_read(REG_SPM_START, '0);
    check_counters();

    // Window read-back and an unmapped offset
    set_windows($random(seed), $random(seed), $random(seed));
    cfg_read(REG_CACHE_START, win_cache_start);
    cfg_read(REG_CACHE_END, win_cache_end);
    cfg_read(REG_SPM_START, win_spm_start);
    cfg_write(8'h20, $random(seed));
    cfg_read(8'h20, UNMAPPED_RDATA);
    cfg_read(REG_CACHE_START, win_cache_start);

    pulse_events(60);
    check_counters();
    for (int k = 0; k < NUM_LLC_EVENTS; k++) begin
      cfg_write(cnt_offs[k], $random(seed));
      model_cnt[k] = '0;
      check_counters();
    end
    pulse_events(30);
    check_counters();

    // Scratchpad overlaps the top of the cached window
    rnd = $random(seed);
    set_windows({4'h1, rnd[11:0], 16'h0}, {4'h1, rnd[11:0], 16'h0} + 32'h0010_0000,
                {4'h1, rnd[11:0], 16'h0} + 32'h000F_8000);
    send_access(ADDR_W'(win_cache_start) - 64'd1, 1'b1);
    send_access(ADDR_W'(win_cache_start), 1'b1);
    send_access(ADDR_W'(win_cache_end) - 64'd1, 1'b1);
    send_access(ADDR_W'(win_cache_end), 1'b1);
    send_access(ADDR_W'(win_spm_start) - 64'd1, 1'b1);
    send_access(ADDR_W'(win_spm_start) + SPM_SIZE - 64'd1, 1'b1);
    send_access(ADDR_W'(win_spm_start) + SPM_SIZE, 1'b1);
    send_access({32'h0000_0001, win_cache_start}, 1'b1);
    base = ADDR_W'(win_cache_start) - 64'h0020_0000;
    for (int i = 0; i < 60; i++) begin
      rnd = $random(seed);
      send_access(base + ADDR_W'(rnd[22:0]), rnd[31] | rnd[30]);
    end
    access_valid_i = 1'b0;

    for (int t = 0; t < 8; t++) begin
      dma_evt_valid_i = ~dma_evt_valid_i;
      dma_toggles++;
      n = 0;
      while (dma_pulses != dma_toggles) begin
        @(posedge clk_i);
        #1;
        n++;
        if (n > 20) report_failure("DMA event pulse never arrived");
      end
      hold_ready_low();
    end
    repeat (10) @(posedge clk_i);

    if (dma_pulses != dma_toggles) begin
      report_mismatch("dma_evt_o pulse count", 64'(dma_toggles), 64'(dma_pulses));
    end else begin
      $display("RESULT: PASS");
      $finish;
    end
  end

endmodule

// File: host_ctrl.f
hdl/host_ctrl_pkg.sv
hdl/llc_cfg_regs.sv
hdl/llc_event_counters.sv
hdl/llc_region_decode.sv
hdl/dma_evt_rx.sv
hdl/host_ctrl_top.sv
tests/host_ctrl_tb.sv

// File: Makefile
TOOL     = verilator
FLAGS    = --binary --timing --assert
TOP      = host_ctrl_tb
FILELIST = host_ctrl.f
OBJ_DIR  = obj_dir
LOG      = sim.log

.PHONY: all lint sim clean

all: sim

lint:
	$(TOOL) --lint-only --timing --assert -f $(FILELIST) --top-module $(TOP)

sim:
	$(TOOL) $(FLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR) -o $(TOP)
	-./$(OBJ_DIR)/$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "RESULT: FAIL" $(LOG); then \
		echo "Simulation reported a failure"; \
		exit 1; \
	fi
	@if ! grep -q "RESULT: PASS" $(LOG); then \
		echo "Simulation ended without a result"; \
		exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
